//--- line_clock_unit.f
hw/line_clock_pkg.sv
hw/csr_access_if.sv
hw/iopage_decode.sv
hw/line_clock_regs.sv
hw/iopage_read_intr.sv
hw/line_clock_unit.sv
test/line_clock_checker.sv
test/tb_line_clock_unit.sv

//--- test/tb_line_clock_unit.sv
/*
 testbench for line_clock_unit with a 40-cycle line period.
 a reference model is stepped on each rising edge and compared after it.
*/

`timescale 1ns/1ns

module tb_line_clock_unit;

   localparam line_clock_pkg::div_count_t tb_tick_div = 20'd40;
   localparam line_clock_pkg::iopage_addr_t csr = 13'o17546;
   localparam int wait_limit = 200;

   logic clk;
   logic reset;
   line_clock_pkg::iopage_addr_t iopage_addr;
   line_clock_pkg::word_t data_in;
   logic iopage_rd;
   logic iopage_wr;
   logic iopage_byte_op;
   logic interrupt_ack;
   line_clock_pkg::word_t data_out;
   logic decode;
   logic interrupt;
   line_clock_pkg::vector_t vector;

   int errors;
   int cycles_since_reset;
   logic [31:0] lcg_state;
   line_clock_pkg::word_t wdata;
   // {done, int_enable, counter}
   logic [21:0] model;

   line_clock_unit #(
      .tick_div (tb_tick_div)
   ) i_dut (
      .clk            (clk),
      .reset          (reset),
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .interrupt_ack  (interrupt_ack),
      .data_out       (data_out),
      .decode         (decode),
      .interrupt      (interrupt),
      .vector         (vector)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // next model state: write first, then tick, then acknowledge
   function automatic logic [21:0] model_step(input logic [21:0] st, input logic rst,
      input logic [12:0] addr, input logic wr, input logic byte_op,
      input logic [15:0] din, input logic ack);
      logic hit;
      logic load;
      logic tick;
      logic dn;
      logic ie;
      logic [19:0] cnt;
      begin
         hit = (addr == 13'o17546) || (addr == 13'o17547);
         load = hit && wr && !(byte_op && addr[0]);
         tick = (st[19:0] == tb_tick_div - 1);
         cnt = tick ? 20'd0 : st[19:0] + 20'd1;
         dn = load ? din[7] : (tick ? 1'b1 : (ack ? 1'b0 : st[21]));
         ie = load ? din[6] : st[20];
         if (rst)
         begin
            return '0;
         end
         return {dn, ie, cnt};
      end
   endfunction

   function automatic line_clock_pkg::word_t expected_data(input logic [21:0] st,
      input logic [12:0] addr, input logic rd, input logic byte_op);
      begin
         if (!rd || (addr != 13'o17546 && addr != 13'o17547))
         begin
            return 16'h0000;
         end
         // odd byte holds no state
         if (byte_op && addr[0])
         begin
            return 16'h0000;
         end
         return {8'h00, st[21], st[20], 6'b000000};
      end
   endfunction

   always
   begin
      @(posedge clk);
      #1;
      model = model_step(model, reset, iopage_addr, iopage_wr, iopage_byte_op,
         data_in, interrupt_ack);
      cycles_since_reset = reset ? 0 : cycles_since_reset + 1;
      if (data_out !== expected_data(model, iopage_addr, iopage_rd, iopage_byte_op))
      begin
         errors++;
         $display("error: data_out = %h, expected %h",
            data_out, expected_data(model, iopage_addr, iopage_rd, iopage_byte_op));
      end
      if (interrupt !== (model[21] & model[20]))
      begin
         errors++;
         $display("error: interrupt = %h, expected %h", interrupt, model[21] & model[20]);
      end
   end

   task automatic drive_bus(input logic [12:0] addr, input logic rd, input logic wr,
      input logic byte_op, input logic [15:0] din, input logic ack);
      @(negedge clk);
      iopage_addr = addr;
      iopage_rd = rd;
      iopage_wr = wr;
      iopage_byte_op = byte_op;
      data_in = din;
      interrupt_ack = ack;
   endtask

   task automatic read_check(input logic [12:0] addr, input logic byte_op,
      input logic [15:0] expected);
      drive_bus(addr, 1'b1, 1'b0, byte_op, 16'h0000, 1'b0);
      #1;
      if (data_out !== expected)
      begin
         errors++;
         $display("error: data_out = %h, expected %h at address %o", data_out, expected, addr);
      end
   endtask

   task automatic check_decode(input logic [12:0] addr, input logic expected);
      drive_bus(addr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b0);
      #1;
      if (decode !== expected)
      begin
         errors++;
         $display("error: decode = %h, expected %h at address %o", decode, expected, addr);
      end
   endtask

   task automatic check_interrupt(input logic expected);
      if (interrupt !== expected)
      begin
         errors++;
         $display("error: interrupt = %h, expected %h", interrupt, expected);
      end
   endtask

   task automatic wait_for_done(input string what);
      int n;
      n = 0;
      drive_bus(csr, 1'b1, 1'b0, 1'b0, 16'h0000, 1'b0);
      #1;
      while (data_out[7] !== 1'b1 && n < wait_limit)
      begin
         drive_bus(csr, 1'b1, 1'b0, 1'b0, 16'h0000, 1'b0);
         #1;
         n++;
      end
      if (n >= wait_limit)
      begin
         errors++;
         $display("timed out waiting for done to set (%s)", what);
      end
   endtask

   initial
   begin
      int n;
      clk = 1'b0;
      reset = 1'b1;
      iopage_addr = '0;
      data_in = '0;
      iopage_rd = 1'b0;
      iopage_wr = 1'b0;
      iopage_byte_op = 1'b0;
      interrupt_ack = 1'b0;
      errors = 0;
      cycles_since_reset = 0;
      model = '0;
      lcg_state = 32'h87c6_8f98;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      read_check(csr, 1'b0, 16'h0000);
      check_decode(13'o17544, 1'b0);
      check_decode(13'o17546, 1'b1);
      check_decode(13'o17547, 1'b1);
      check_decode(13'o17550, 1'b0);

      // ticks every 40 cycles from reset
      wait_for_done("first tick");
      if (cycles_since_reset != 40)
      begin
         errors++;
         $display("done first set after %0d cycles instead of 40", cycles_since_reset);
      end
      drive_bus(csr, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0);
      wait_for_done("second tick");
      if (cycles_since_reset != 80)
      begin
         errors++;
         $display("done set again after %0d cycles instead of 80", cycles_since_reset);
      end

      // random word writes keep bits 7 and 6 only
      repeat (6)
      begin
         lcg_state = lcg_next(lcg_state);
         wdata = lcg_state[31:16];
         drive_bus(csr, 1'b0, 1'b1, 1'b0, wdata, 1'b0);
         read_check(csr, 1'b0, wdata & 16'h00c0);
      end
      drive_bus(csr, 1'b0, 1'b1, 1'b0, 16'h0080, 1'b0);
      drive_bus(13'o17547, 1'b0, 1'b1, 1'b1, 16'hffff, 1'b0);
      read_check(csr, 1'b0, 16'h0080);
      read_check(13'o17546, 1'b1, 16'h0080);
      read_check(13'o17547, 1'b1, 16'h0000);

      // interrupt rises with done, ack clears it
      drive_bus(csr, 1'b0, 1'b1, 1'b0, 16'h0040, 1'b0);
      wait_for_done("interrupt");
      check_interrupt(1'b1);
      if (vector !== 8'o100)
      begin
         errors++;
         $display("error: vector = %h, expected %h", vector, 8'o100);
      end
      drive_bus(csr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b1);
      drive_bus(csr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b0);
      #1;
      check_interrupt(1'b0);
      drive_bus(csr, 1'b0, 1'b1, 1'b0, 16'h00c0, 1'b1);
      read_check(csr, 1'b0, 16'h00c0);
      check_interrupt(1'b1);
      drive_bus(csr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b1);
      n = 0;
      while ((cycles_since_reset % tb_tick_div) != 38 && n < wait_limit)
      begin
         drive_bus(csr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b0);
         n++;
      end
      if (n >= wait_limit)
      begin
         errors++;
         $display("timed out waiting for the cycle before a tick");
      end
      // ack lands on the tick edge and loses
      drive_bus(csr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b1);
      read_check(csr, 1'b0, 16'h00c0);
      check_interrupt(1'b1);

      // neighbors see nothing
      drive_bus(13'o17544, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0);
      drive_bus(13'o17550, 1'b0, 1'b1, 1'b0, 16'h0000, 1'b0);
      read_check(13'o17544, 1'b0, 16'h0000);
      read_check(13'o17550, 1'b0, 16'h0000);
      read_check(csr, 1'b0, 16'h00c0);

      drive_bus(csr, 1'b0, 1'b0, 1'b0, 16'h0000, 1'b0);
      repeat (2) @(negedge clk);
      $display("checks finished with %0d errors", errors);
      if (errors == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

//--- test/line_clock_checker.sv
/*
 assertions on the line clock top level, bound into every instance.
 internal done and int_enable are reached through the bind port list.
*/

`timescale 1ns/1ns

module line_clock_checker (
   input logic                    clk,
   input logic                    reset,
   input logic                    iopage_rd,
   input line_clock_pkg::word_t   data_out,
   input logic                    interrupt,
   input line_clock_pkg::vector_t vector,
   input logic                    done,
   input logic                    int_enable
);

   // request is exactly done AND interrupt enable
   assert property (@(posedge clk) disable iff (reset) interrupt == (done & int_enable))
      else $error("interrupt does not match done and interrupt enable");

   assert property (@(posedge clk) vector == 8'o100)
      else $error("vector is not octal 100");

   // bus stays quiet without a read
   assert property (@(posedge clk) disable iff (reset) !iopage_rd |-> data_out == '0)
      else $error("data_out driven while rd is low");

   assert property (@(posedge clk) reset |=> !interrupt)
      else $error("interrupt high in the cycle after reset");

endmodule

bind line_clock_unit line_clock_checker i_checker (
   .clk        (clk),
   .reset      (reset),
   .iopage_rd  (iopage_rd),
   .data_out   (data_out),
   .interrupt  (interrupt),
   .vector     (vector),
   .done       (done),
   .int_enable (int_enable)
);

//--- hw/line_clock_unit.sv
/*
 KW11L line-time clock, slave on the I/O page bus.
 CSR at 777546, vector 100. tick_div sets the line period in clocks.
 no arbitration here; interrupt_ack comes from the bus master.
*/

`timescale 1ns/1ns

module line_clock_unit #(
   parameter line_clock_pkg::div_count_t tick_div = line_clock_pkg::default_tick_div
) (
   input  logic                         clk,
   input  logic                         reset,
   input  line_clock_pkg::iopage_addr_t iopage_addr,
   input  line_clock_pkg::word_t        data_in,
   input  logic                         iopage_rd,
   input  logic                         iopage_wr,
   input  logic                         iopage_byte_op,
   input  logic                         interrupt_ack,
   output line_clock_pkg::word_t        data_out,
   output logic                         decode,
   output logic                         interrupt,
   output line_clock_pkg::vector_t      vector
);

   csr_access_if acc ();

   logic rd_sel;
   logic byte_high;
   logic done;
   logic int_enable;

   // raw address match for the bus
   assign decode = acc.sel;

   iopage_decode i_decode (
      .iopage_addr    (iopage_addr),
      .data_in        (data_in),
      .iopage_rd      (iopage_rd),
      .iopage_wr      (iopage_wr),
      .iopage_byte_op (iopage_byte_op),
      .acc            (acc.decoder),
      .rd_sel         (rd_sel),
      .byte_high      (byte_high)
   );

   line_clock_regs #(
      .tick_div (tick_div)
   ) i_regs (
      .clk           (clk),
      .reset         (reset),
      .acc           (acc.regs),
      .interrupt_ack (interrupt_ack),
      .done          (done),
      .int_enable    (int_enable)
   );

   iopage_read_intr i_read_intr (
      .rd_sel         (rd_sel),
      .iopage_byte_op (iopage_byte_op),
      .byte_high      (byte_high),
      .done           (done),
      .int_enable     (int_enable),
      .data_out       (data_out),
      .interrupt      (interrupt),
      .vector         (vector)
   );

endmodule

//--- hw/iopage_read_intr.sv
/*
 CSR read path and interrupt request.
 data_out is zero unless a read hits the CSR; reads are levels.
 byte reads return the addressed byte in bits 7:0.
*/

`timescale 1ns/1ns

module iopage_read_intr (
   input  logic                         rd_sel,
   input  logic                         iopage_byte_op,
   input  logic                         byte_high,
   input  logic                         done,
   input  logic                         int_enable,
   output line_clock_pkg::word_t        data_out,
   output logic                         interrupt,
   output line_clock_pkg::vector_t      vector
);

   line_clock_pkg::word_t csr_word;
   line_clock_pkg::word_t read_word;

   // CSR image, all other bits read as zero
   always_comb
   begin
      csr_word = '0;
      csr_word[line_clock_pkg::csr_done_bit] = done;
      csr_word[line_clock_pkg::csr_ie_bit] = int_enable;
   end

   // nothing on the bus without a read hit
   always_comb
   begin
      if (rd_sel)
      begin
         read_word = csr_word;
      end
      else
      begin
         read_word = '0;
      end
   end

   // byte lane select
   always_comb
   begin
      if (!iopage_byte_op)
      begin
         data_out = read_word;
      end
      else if (byte_high)
      begin
         data_out = {8'b0, read_word[15:8]};
      end
      else
      begin
         data_out = {8'b0, read_word[7:0]};
      end
   end

   // request stays up until done is cleared
   assign interrupt = done & int_enable;

   assign vector = line_clock_pkg::clock_vector;

endmodule

//--- hw/line_clock_regs.sv
/*
 KW11L divider and CSR state.
 tick_div must be at least 2. a write wins over a tick,
 and a tick wins over interrupt_ack in the same cycle.
*/

`timescale 1ns/1ns

module line_clock_regs #(
   parameter line_clock_pkg::div_count_t tick_div = line_clock_pkg::default_tick_div
) (
   input  logic          clk,
   input  logic          reset,
   csr_access_if.regs    acc,
   input  logic          interrupt_ack,
   output logic          done,
   output logic          int_enable
);

   line_clock_pkg::div_count_t counter;
   logic tick;
   logic csr_load;

   // last count of the line period
   assign tick = (counter == tick_div - 1'b1);

   // only a write touching the low byte changes the CSR
   assign csr_load = acc.sel & acc.wr & acc.wr_low;

   // free-running divider, 0 .. tick_div-1
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         counter <= '0;
      end
      else if (tick)
      begin
         counter <= '0;
      end
      else
      begin
         counter <= counter + 1'b1;
      end
   end

   // done: write, then tick, then acknowledge
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done <= 1'b0;
      end
      else if (csr_load)
      begin
         done <= acc.wdata[line_clock_pkg::csr_done_bit];
      end
      else if (tick)
      begin
         done <= 1'b1;
      end
      else if (interrupt_ack)
      begin
         done <= 1'b0;
      end
   end

   // interrupt enable changes only by a write
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         int_enable <= 1'b0;
      end
      else if (csr_load)
      begin
         int_enable <= acc.wdata[line_clock_pkg::csr_ie_bit];
      end
   end

endmodule

//--- hw/iopage_decode.sv
/*
 CSR address decode for the line clock.
 both byte addresses of the CSR word match; no wait states.
 purely combinational.
*/

`timescale 1ns/1ns

module iopage_decode (
   input  line_clock_pkg::iopage_addr_t iopage_addr,
   input  line_clock_pkg::word_t        data_in,
   input  logic                         iopage_rd,
   input  logic                         iopage_wr,
   input  logic                         iopage_byte_op,
   csr_access_if.decoder                acc,
   output logic                         rd_sel,
   output logic                         byte_high
);

   logic addr_match;
   logic odd_byte;

   // ignore bit 0 so 17546 and 17547 both hit
   assign addr_match = (iopage_addr[12:1] == line_clock_pkg::csr_addr[12:1]);

   // byte access aimed at bits 15:8
   assign odd_byte = iopage_byte_op & iopage_addr[0];

   assign acc.sel = addr_match;

   // strobes only count on a hit
   assign acc.wr = iopage_wr & addr_match;
   assign rd_sel = iopage_rd & addr_match;

   // the state bits live in the low byte, data needs no shifting
   assign acc.wdata = data_in;

   // word writes and even byte writes reach the low byte
   assign acc.wr_low = ~odd_byte;

   // odd byte read, result block returns the high byte
   assign byte_high = iopage_rd & odd_byte;

endmodule

//--- hw/csr_access_if.sv
/*
 one decoded CSR access, from the address decoder to the registers.
 purely combinational, no clock inside.
*/

`timescale 1ns/1ns

interface csr_access_if;

   // address hits the CSR word, either byte
   logic sel;

   // write strobe qualified by sel
   logic wr;

   // write data as seen by the register
   line_clock_pkg::word_t wdata;

   // write reaches bits 7:0
   logic wr_low;

   modport decoder (
      output sel,
      output wr,
      output wdata,
      output wr_low
   );

   modport regs (
      input sel,
      input wr,
      input wdata,
      input wr_low
   );

endinterface

//--- hw/line_clock_pkg.sv
/*
 KW11L line clock constants for the I/O page bus.
 the default divisor assumes a 50 MHz clock and 60 Hz mains.
 only done (bit 7) and interrupt enable (bit 6) hold state.
*/

package line_clock_pkg;

   // 13-bit I/O page byte address
   typedef logic [12:0] iopage_addr_t;

   // bus data word
   typedef logic [15:0] word_t;

   // interrupt vector as placed on the bus
   typedef logic [7:0] vector_t;

   // divider count, wide enough for 50 MHz / 60 Hz
   typedef logic [19:0] div_count_t;

   // CSR at full address 777546
   localparam iopage_addr_t csr_addr = 13'o17546;

   // CSR bit positions
   localparam int csr_done_bit = 7;
   localparam int csr_ie_bit = 6;

   // fixed vector of the line clock
   localparam vector_t clock_vector = 8'o100;

   // 50000000 / 60, truncated
   localparam div_count_t default_tick_div = 20'd833333;

endpackage
